// ==== hw/ks10Pkg.sv ====
/* Shared types of the KS10 interrupt unit: data-path word, PI levels and masks,
   APR and PI command layouts, interrupt status and the level priority encoder */

`default_nettype none

package ks10Pkg;

   //////////////////////////////
   // Basic types
   //////////////////////////////

   typedef logic [35:0] wordT;                  // Data-path word
   typedef logic [ 2:0] levelT;                 // PI level, 0 is none, 1 is highest
   typedef logic [ 1:7] levelMaskT;             // One bit per level 1..7
   typedef logic [ 7:0] aprFlagT;               // APR flags
   typedef logic [17:0] timerCountT;            // Interval timer count

   localparam int cslFlag = 7;                  // Console interrupt flag

   //////////////////////////////
   // Command words
   //////////////////////////////

   // Data-path word seen by an APR write
   typedef struct packed {
      logic [16:0] spare0;
      logic        doEnable;                    // Add selected enables
      logic        doDisable;                   // Remove selected enables
      logic        doClear;                     // Remove selected flags
      logic        doSet;                       // Add selected flags
      aprFlagT     flagSel;
      logic [ 3:0] spare1;
      levelT       aprLevel;                    // PI level of the APR request
   } aprCmdT;

   // Data-path word seen by a PI write
   typedef struct packed {
      logic [18:0] spare0;
      logic        clearAll;                    // Reset the whole PI system
      logic        systemOn;
      logic        systemOff;
      logic        levelOn;
      logic        levelOff;
      logic [ 4:0] spare1;
      levelMaskT   levelSel;
   } piCmdT;

   // One word, decoded by whichever write strobe is active
   typedef union packed {
      wordT   word;
      aprCmdT apr;
      piCmdT  pi;
   } dpWordU;

   // Interrupt status to the processor
   typedef struct packed {
      levelT reqIntp;                           // Requested priority
      levelT curIntp;                           // Current priority
      logic  cpuIntr;                           // Interrupt the CPU
   } intrStatusT;

   //////////////////////////////
   // Priority encoder
   //////////////////////////////

   // Lowest numbered level set in the mask, 0 when empty
   function automatic levelT lowestLevel(input levelMaskT mask);
      levelT lvl;
      lvl = '0;
      for (int i = 7; i >= 1; i--) begin
         if (mask[i]) lvl = levelT'(i);         // Later hits win, so level 1 last
      end
      return lvl;
   endfunction

endpackage

`default_nettype wire

// ==== hw/intervalTimer.sv ====
/* Interval timer: counts enabled clock cycles modulo timerPeriod
   and pulses timerIntr for one cycle after each wrap */

`default_nettype none
`timescale 1ns/100ps

module intervalTimer #(
   parameter int timerPeriod = 4096             // Counts per wrap from 2 to 2**18
) (
   input  wire logic               clk,
   input  wire logic               rstN,
   input  wire logic               timerEn,     // Count this cycle
   output      ks10Pkg::timerCountT timerCount,
   output      logic               timerIntr    // One cycle after a wrap
);

   import ks10Pkg::*;

   localparam timerCountT lastCount = timerCountT'(timerPeriod - 1);

   logic wrap;

   assign wrap = timerEn && (timerCount == lastCount);

   //////////////////////////////
   // Counter and wrap pulse
   //////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         timerCount <= '0;
         timerIntr  <= 1'b0;
      end else begin
         timerIntr <= wrap;                     // High for the cycle after the wrap
         if (wrap) begin
            timerCount <= '0;
         end else if (timerEn) begin
            timerCount <= timerCount + 1'b1;
         end
      end
   end

   // Count never reaches the period
   aCountRange : assert property (
      @(posedge clk) disable iff (!rstN)
      timerCount < timerPeriod
   ) else $error("timer count %0d out of range", timerCount);

endmodule

`default_nettype wire

// ==== hw/aprFlags.sv ====
/* APR flag and enable registers with the APR PI level,
   the resulting APR interrupt request and the console interrupt flag */

`default_nettype none
`timescale 1ns/100ps

module aprFlags (
   input  wire logic              clk,
   input  wire logic              rstN,
   input  wire logic              aprWrite,     // Write strobe for dpIn
   input  wire ks10Pkg::dpWordU   dpIn,
   input  wire logic              ks10Intr,     // Console interrupt to KS10
   output      ks10Pkg::levelMaskT aprReq,      // At most one level
   output      logic              cslIntr       // KS10 interrupt to console
);

   import ks10Pkg::*;

   aprCmdT  cmd;
   aprFlagT flagReg;                            // APR flags
   aprFlagT enableReg;                          // Flag interrupt enables
   levelT   aprLevel;                           // PI level for APR request
   aprFlagT flagNext;
   aprFlagT enableNext;
   logic    reqActive;

   assign cmd = dpIn.apr;

   //////////////////////////////
   // Write decode
   //////////////////////////////

   always_comb begin
      flagNext   = flagReg;
      enableNext = enableReg;
      if (aprWrite) begin
         if (cmd.doClear)   flagNext   = flagNext & ~cmd.flagSel;
         if (cmd.doSet)     flagNext   = flagNext | cmd.flagSel;     // Set wins
         if (cmd.doDisable) enableNext = enableNext & ~cmd.flagSel;
         if (cmd.doEnable)  enableNext = enableNext | cmd.flagSel;   // Enable wins
      end
      // Console interrupt beats a clear in the same cycle
      if (ks10Intr) flagNext[cslFlag] = 1'b1;
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         flagReg   <= '0;
         enableReg <= '0;
         aprLevel  <= '0;
      end else begin
         flagReg   <= flagNext;
         enableReg <= enableNext;
         if (aprWrite) begin
            aprLevel <= cmd.aprLevel;           // Loaded on every APR write
         end
      end
   end

   //////////////////////////////
   // Request outputs
   //////////////////////////////

   assign reqActive = |(flagReg & enableReg);   // Any enabled flag set

   always_comb begin
      aprReq = '0;
      if (reqActive && aprLevel != '0) begin
         aprReq[aprLevel] = 1'b1;
      end
   end

   assign cslIntr = flagReg[cslFlag];

   // The request targets a single PI level
   aOneLevel : assert property (
      @(posedge clk) disable iff (!rstN)
      $onehot0(aprReq)
   ) else $error("APR request on more than one level");

endmodule

`default_nettype wire

// ==== hw/piArbiter.sv ====
/* Priority-interrupt arbiter: PI system state, enabled and in-progress levels,
   priority encoding of pending requests and the registered interrupt status */

`default_nettype none
`timescale 1ns/100ps

module piArbiter (
   input  wire logic               clk,
   input  wire logic               rstN,
   input  wire ks10Pkg::levelMaskT busIntr,     // Unibus requests
   input  wire ks10Pkg::levelMaskT aprReq,      // APR request
   input  wire logic               aprWrite,    // Only checked against piWrite
   input  wire logic               piWrite,     // Write strobe for dpIn
   input  wire ks10Pkg::dpWordU    dpIn,
   input  wire logic               intrAck,     // Take the requested level
   input  wire logic               intrDismiss, // Release the current level
   output      ks10Pkg::intrStatusT intrStatus
);

   import ks10Pkg::*;

   piCmdT      cmd;
   logic       systemOn;                        // PI system on
   levelMaskT  levelEnable;                     // Enabled levels
   levelMaskT  inProgress;                      // Levels being serviced
   logic       systemNext;
   levelMaskT  enableNext;
   levelMaskT  progressNext;
   levelMaskT  pending;
   intrStatusT statusNext;

   assign cmd = dpIn.pi;

   //////////////////////////////
   // PI state update
   //////////////////////////////

   always_comb begin
      systemNext   = systemOn;
      enableNext   = levelEnable;
      progressNext = inProgress;
      if (piWrite) begin
         if (cmd.clearAll) begin
            systemNext   = 1'b0;
            enableNext   = '0;
            progressNext = '0;
         end
         if (cmd.systemOff) systemNext = 1'b0;
         if (cmd.systemOn)  systemNext = 1'b1;
         if (cmd.levelOff)  enableNext = enableNext & ~cmd.levelSel;
         if (cmd.levelOn)   enableNext = enableNext | cmd.levelSel;
      end
      // Dismiss first so ack of the same level sticks
      if (intrDismiss && intrStatus.curIntp != '0) begin
         progressNext[intrStatus.curIntp] = 1'b0;
      end
      if (intrAck && intrStatus.reqIntp != '0) begin
         progressNext[intrStatus.reqIntp] = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         systemOn    <= 1'b0;
         levelEnable <= '0;
         inProgress  <= '0;
      end else begin
         systemOn    <= systemNext;
         levelEnable <= enableNext;
         inProgress  <= progressNext;
      end
   end

   //////////////////////////////
   // Priority encoding
   //////////////////////////////

   assign pending = (busIntr | aprReq) & levelEnable & {7{systemOn}};

   always_comb begin
      statusNext.reqIntp = lowestLevel(pending);
      statusNext.curIntp = lowestLevel(inProgress);
      // Interrupt only for a strictly higher priority than the one in service
      statusNext.cpuIntr = (statusNext.reqIntp != '0) &&
                           ((statusNext.curIntp == '0) ||
                            (statusNext.reqIntp < statusNext.curIntp));
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         intrStatus <= '0;
      end else begin
         intrStatus <= statusNext;
      end
   end

   //////////////////////////////
   // Protocol checks
   //////////////////////////////

   // APR and PI writes share the data-path word
   aOneWriter : assert property (
      @(posedge clk) disable iff (!rstN)
      !(aprWrite && piWrite)
   ) else $error("APR and PI write in the same cycle");

   aAckValid : assert property (
      @(posedge clk) disable iff (!rstN)
      intrAck |-> intrStatus.cpuIntr
   ) else $error("interrupt ack without cpuIntr");

   aDismissValid : assert property (
      @(posedge clk) disable iff (!rstN)
      intrDismiss |-> (intrStatus.curIntp != '0)
   ) else $error("interrupt dismiss with no level in progress");

endmodule

`default_nettype wire

// ==== hw/ks10IntrUnit.sv ====
/* KS10 interrupt unit top level
   Interval timer, APR flags and PI arbiter joined */

`default_nettype none
`timescale 1ns/100ps

module ks10IntrUnit #(
   parameter int timerPeriod = 4096             // Timer counts per wrap
) (
   input  wire logic                clk,
   input  wire logic                rstN,
   input  wire logic                cslTimerEn,  // Timer enable from console
   input  wire logic                ks10Intr,    // Console interrupt to KS10
   input  wire ks10Pkg::levelMaskT  busIntr,     // Unibus interrupt requests
   input  wire logic                aprWrite,    // APR write strobe
   input  wire logic                piWrite,     // PI write strobe
   input  wire ks10Pkg::dpWordU     dpIn,        // Data-path word
   input  wire logic                intrAck,
   input  wire logic                intrDismiss,
   output      logic                timerIntr,   // Trap to the microsequencer
   output      ks10Pkg::timerCountT timerCount,
   output      logic                cslIntr,     // KS10 interrupt to console
   output      ks10Pkg::intrStatusT intrStatus
);

   import ks10Pkg::*;

   levelMaskT aprReq;                           // APR request level

   //////////////////////////////
   // Interval timer
   //////////////////////////////

   intervalTimer #(
      .timerPeriod (timerPeriod)
   ) uTimer (
      .clk         (clk),
      .rstN        (rstN),
      .timerEn     (cslTimerEn),
      .timerCount  (timerCount),
      .timerIntr   (timerIntr)
   );

   //////////////////////////////
   // APR flags
   //////////////////////////////

   aprFlags uAprFlags (
      .clk         (clk),
      .rstN        (rstN),
      .aprWrite    (aprWrite),
      .dpIn        (dpIn),
      .ks10Intr    (ks10Intr),
      .aprReq      (aprReq),
      .cslIntr     (cslIntr)
   );

   //////////////////////////////
   // Interrupt arbiter
   //////////////////////////////

   piArbiter uPiArbiter (
      .clk         (clk),
      .rstN        (rstN),
      .busIntr     (busIntr),
      .aprReq      (aprReq),
      .aprWrite    (aprWrite),                  // Write conflict check
      .piWrite     (piWrite),
      .dpIn        (dpIn),
      .intrAck     (intrAck),
      .intrDismiss (intrDismiss),
      .intrStatus  (intrStatus)
   );

endmodule

`default_nettype wire

// ==== include/ks10RefModel.svh ====
/* Reference model of the KS10 interrupt unit: model state, input and output
   records, reset and the cycle step that predicts every DUT output */

`ifndef KS10_REF_MODEL_SVH
`define KS10_REF_MODEL_SVH

// Inputs sampled at one clock edge
typedef struct packed {
   logic               timerEn;
   logic               ks10Intr;
   ks10Pkg::levelMaskT busIntr;
   logic               aprWrite;
   logic               piWrite;
   ks10Pkg::dpWordU    dpIn;
   logic               intrAck;
   logic               intrDismiss;
} refInT;

// Predicted outputs after that edge
typedef struct packed {
   ks10Pkg::timerCountT timerCount;
   logic                timerIntr;
   logic                cslIntr;
   ks10Pkg::intrStatusT intrStatus;
} refOutT;

// Every register of the unit
typedef struct packed {
   ks10Pkg::timerCountT timerCount;
   logic                timerIntr;
   ks10Pkg::aprFlagT    flags;
   ks10Pkg::aprFlagT    enables;
   ks10Pkg::levelT      aprLevel;
   logic                systemOn;
   ks10Pkg::levelMaskT  levelEnable;
   ks10Pkg::levelMaskT  inProgress;
   ks10Pkg::intrStatusT status;
} refStateT;

refStateT refState;

function automatic void refReset();
   refState = '0;
endfunction

// Scan up from level 1, first hit is the highest priority
function automatic ks10Pkg::levelT refLowest(input ks10Pkg::levelMaskT mask);
   ks10Pkg::levelT lvl;
   lvl = '0;
   for (int i = 1; i <= 7; i++) begin
      if (mask[i] && lvl == '0) lvl = ks10Pkg::levelT'(i);
   end
   return lvl;
endfunction

// One clock edge, all next values from the old state
function automatic refOutT refStep(input refInT in, input int unsigned period);
   refStateT           old;
   ks10Pkg::aprCmdT    apr;
   ks10Pkg::piCmdT     pi;
   ks10Pkg::levelMaskT aprMask;
   ks10Pkg::levelMaskT pending;
   refOutT             out;
   old = refState;
   apr = in.dpIn.apr;
   pi  = in.dpIn.pi;
   refState.timerIntr = in.timerEn && (old.timerCount == period - 1);
   if (in.timerEn) begin
      refState.timerCount = refState.timerIntr ? '0 : old.timerCount + 1'b1;
   end
   aprMask = '0;                                // Request from old APR registers
   if ((|(old.flags & old.enables)) && old.aprLevel != '0) aprMask[old.aprLevel] = 1'b1;
   if (in.aprWrite) begin
      if (apr.doClear)   refState.flags   = refState.flags & ~apr.flagSel;
      if (apr.doSet)     refState.flags   = refState.flags | apr.flagSel;
      if (apr.doDisable) refState.enables = refState.enables & ~apr.flagSel;
      if (apr.doEnable)  refState.enables = refState.enables | apr.flagSel;
      refState.aprLevel = apr.aprLevel;
   end
   if (in.ks10Intr) refState.flags[7] = 1'b1;
   pending = old.systemOn ? ((in.busIntr | aprMask) & old.levelEnable) : '0;
   refState.status.reqIntp = refLowest(pending);
   refState.status.curIntp = refLowest(old.inProgress);
   refState.status.cpuIntr = (refState.status.reqIntp != '0) &&
                             ((refState.status.curIntp == '0) ||
                              (refState.status.reqIntp < refState.status.curIntp));
   if (in.piWrite) begin
      if (pi.clearAll) begin
         refState.systemOn    = 1'b0;
         refState.levelEnable = '0;
         refState.inProgress  = '0;
      end
      if (pi.systemOff) refState.systemOn = 1'b0;
      if (pi.systemOn)  refState.systemOn = 1'b1;
      if (pi.levelOff)  refState.levelEnable = refState.levelEnable & ~pi.levelSel;
      if (pi.levelOn)   refState.levelEnable = refState.levelEnable | pi.levelSel;
   end
   if (in.intrDismiss && old.status.curIntp != '0) begin
      refState.inProgress[old.status.curIntp] = 1'b0;
   end
   if (in.intrAck && old.status.reqIntp != '0) begin
      refState.inProgress[old.status.reqIntp] = 1'b1;
   end
   out.timerCount = refState.timerCount;
   out.timerIntr  = refState.timerIntr;
   out.cslIntr    = refState.flags[7];
   out.intrStatus = refState.status;
   return out;
endfunction

`endif

// ==== tb/ks10IntrTb.sv ====
/* Testbench for the KS10 interrupt unit with a cycle-by-cycle model compare,
   directed timer, APR, PI and nesting tests and an LCG random mix */

`default_nettype none
`timescale 1ns/100ps

module ks10IntrTb;

   import ks10Pkg::*;

   `include "ks10RefModel.svh"

   localparam int period       = 16;               // Short period for quick wraps
   localparam int randomCycles = 2000;
   localparam int cycleLimit   = 2 * randomCycles; // Random mix plus directed tests

   logic        clk = 1'b0;
   logic        rstN;
   refInT       drv;                               // DUT inputs besides clk and rstN
   refOutT      dutOut;
   refOutT      expOut;
   logic [31:0] lcgState   = 32'd37108;
   int          cycleCount = 0;
   int          checkCount = 0;
   int          errCount   = 0;
   int          testErrs   = 0;

   ks10IntrUnit #(
      .timerPeriod (period)
   ) dut0 (
      .clk         (clk),
      .rstN        (rstN),
      .cslTimerEn  (drv.timerEn),
      .ks10Intr    (drv.ks10Intr),
      .busIntr     (drv.busIntr),
      .aprWrite    (drv.aprWrite),
      .piWrite     (drv.piWrite),
      .dpIn        (drv.dpIn),
      .intrAck     (drv.intrAck),
      .intrDismiss (drv.intrDismiss),
      .timerIntr   (dutOut.timerIntr),
      .timerCount  (dutOut.timerCount),
      .cslIntr     (dutOut.cslIntr),
      .intrStatus  (dutOut.intrStatus)
   );

   always #20 clk = ~clk;

   //////////////////////////////
   // Model and compare
   //////////////////////////////

   task automatic checkValue(input logic [35:0] got, input logic [35:0] want,
                             input string what);
      checkCount++;
      if (got !== want) begin
         errCount++;
         $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, want);
      end
   endtask

   // Model steps on the same inputs the DUT samples at this edge
   always @(posedge clk) begin
      if (!rstN) begin
         refReset();
         expOut = '0;
      end else begin
         expOut = refStep(drv, period);
      end
   end

   always @(negedge clk) begin
      if (cycleCount > 0) begin
         checkValue(dutOut.timerCount, expOut.timerCount, "timerCount");
         checkValue(dutOut.timerIntr, expOut.timerIntr, "timerIntr");
         checkValue(dutOut.cslIntr, expOut.cslIntr, "cslIntr");
         checkValue(dutOut.intrStatus, expOut.intrStatus, "intrStatus");
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout: run did not end within %0d cycles", cycleLimit);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   function automatic logic [31:0] lcgRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Outputs after the coming edge, model state left as it was
   function automatic refOutT peekNext();
      refStateT saved;
      refOutT   nxt;
      saved    = refState;
      nxt      = refStep(drv, period);
      refState = saved;
      return nxt;
   endfunction

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
   endtask

   // ops holds doEnable, doDisable, doClear, doSet
   task automatic writeApr(input logic [3:0] ops, input aprFlagT sel, input levelT lvl,
                           input logic csl);
      @(posedge clk);
      drv.aprWrite  <= 1'b1;
      drv.ks10Intr  <= csl;
      drv.dpIn.word <= {17'b0, ops, sel, 4'b0, lvl};
      @(posedge clk);
      drv.aprWrite  <= 1'b0;
      drv.ks10Intr  <= 1'b0;
      idle(2);                                     // Status settles
   endtask

   // ops holds clearAll, systemOn, systemOff, levelOn, levelOff
   task automatic writePi(input logic [4:0] ops, input levelMaskT sel);
      @(posedge clk);
      drv.piWrite   <= 1'b1;
      drv.dpIn.word <= {19'b0, ops, 5'b0, sel};
      @(posedge clk);
      drv.piWrite   <= 1'b0;
      idle(2);
   endtask

   task automatic driveIntr(input levelMaskT bus, input logic ack, input logic dismiss);
      @(posedge clk);
      drv.busIntr     <= bus;
      drv.intrAck     <= ack;
      drv.intrDismiss <= dismiss;
      @(posedge clk);
      drv.intrAck     <= 1'b0;
      drv.intrDismiss <= 1'b0;
      idle(2);
   endtask

   task automatic expectStatus(input levelT req, input levelT cur, input logic intr);
      @(negedge clk);
      checkValue(dutOut.intrStatus, {req, cur, intr}, "settled intrStatus");
   endtask

   task automatic endTest(input string name);
      $display("Test %s done, %0d errors", name, errCount - testErrs);
      testErrs = errCount;
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   initial begin : stimulus
      logic [31:0] r;
      logic [31:0] w0;
      logic [31:0] w1;
      refOutT      nxt;
      drv  = '0;
      rstN = 1'b0;
      idle(2);
      rstN <= 1'b1;

      repeat (100) begin                           // Timer with a random enable
         r = lcgRand();
         @(posedge clk);
         drv.timerEn <= r[31];
      end
      @(posedge clk);
      drv.timerEn <= 1'b0;
      endTest("timer");

      writePi(5'b01010, 7'b1111111);               // System on, all levels
      writeApr(4'b1001, 8'h01, 3'd5, 1'b0);        // Flag 0 set and enabled at level 5
      expectStatus(3'd5, 3'd0, 1'b1);
      writeApr(4'b0011, 8'h09, 3'd5, 1'b0);        // Set beats clear
      writeApr(4'b0010, 8'h09, 3'd2, 1'b0);
      expectStatus(3'd0, 3'd0, 1'b0);
      writeApr(4'b1000, 8'h80, 3'd2, 1'b1);        // Console flag enabled and raised
      expectStatus(3'd2, 3'd0, 1'b1);
      checkValue(dutOut.cslIntr, 1'b1, "settled cslIntr");
      writeApr(4'b0010, 8'h80, 3'd2, 1'b1);        // ks10Intr beats the clear
      writeApr(4'b0110, 8'hFF, 3'd0, 1'b0);
      endTest("APR flags");

      writePi(5'b10000, 7'b0);
      driveIntr(7'b0010100, 1'b0, 1'b0);           // Levels 3 and 5
      writePi(5'b01010, 7'b0000100);
      expectStatus(3'd5, 3'd0, 1'b1);
      writePi(5'b00010, 7'b0010000);
      expectStatus(3'd3, 3'd0, 1'b1);
      writePi(5'b00100, 7'b0);                     // System off hides everything
      expectStatus(3'd0, 3'd0, 1'b0);
      writePi(5'b01001, 7'b0010000);
      expectStatus(3'd5, 3'd0, 1'b1);
      writePi(5'b10000, 7'b0);
      expectStatus(3'd0, 3'd0, 1'b0);
      endTest("PI system");

      writePi(5'b11010, 7'b1111111);
      driveIntr(7'b0001000, 1'b0, 1'b0);
      driveIntr(7'b0001000, 1'b1, 1'b0);           // Take level 4
      expectStatus(3'd4, 3'd4, 1'b0);
      driveIntr(7'b0001010, 1'b0, 1'b0);           // Level 6 has to wait
      expectStatus(3'd4, 3'd4, 1'b0);
      driveIntr(7'b0101010, 1'b0, 1'b0);
      expectStatus(3'd2, 3'd4, 1'b1);
      driveIntr(7'b0101010, 1'b1, 1'b0);
      expectStatus(3'd2, 3'd2, 1'b0);
      driveIntr(7'b0101010, 1'b0, 1'b1);           // Back to level 4
      expectStatus(3'd2, 3'd4, 1'b1);
      driveIntr(7'b0000000, 1'b0, 1'b1);
      expectStatus(3'd0, 3'd0, 1'b0);
      endTest("nesting");

      repeat (randomCycles) begin
         @(negedge clk);
         nxt = peekNext();                         // Status the strobes will meet
         r   = lcgRand();
         w0  = lcgRand();
         w1  = lcgRand();
         @(posedge clk);
         drv.timerEn     <= r[31];
         drv.ks10Intr    <= (r[30:27] == 4'd0);
         drv.busIntr     <= r[26:20];
         drv.aprWrite    <= (r[19:17] == 3'd0);
         drv.piWrite     <= (r[19:17] == 3'd1);
         drv.intrAck     <= r[16] && nxt.intrStatus.cpuIntr;
         drv.intrDismiss <= (r[15:14] == 2'd0) && (nxt.intrStatus.curIntp != 3'd0);
         drv.dpIn.word   <= {r[13:10], w0[31:16], w1[31:16]};
      end
      @(posedge clk);
      drv <= '0;
      idle(3);
      endTest("random mix");

      $display("Summary: %0d checks, %0d errors", checkCount, errCount);
      if (errCount == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hw/ks10Pkg.sv
hw/intervalTimer.sv
hw/aprFlags.sv
hw/piArbiter.sv
hw/ks10IntrUnit.sv
tb/ks10IntrTb.sv
